//--- design/exec_unit.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module exec_unit (
  input  rv_core_pkg::fetch_pkt_t pkt,
  output rv_core_pkg::reg_idx_t   rs1,
  output rv_core_pkg::reg_idx_t   rs2,
  input  rv_core_pkg::word_t      rs1_data,
  input  rv_core_pkg::word_t      rs2_data,
  output rv_core_pkg::mem_idx_t   dmem_idx,
  input  rv_core_pkg::word_t      dmem_data,
  output rv_core_pkg::rf_wr_t     rf_wr,
  output rv_core_pkg::dm_wr_t     dm_wr,
  output rv_core_pkg::redirect_t  redirect,
  output rv_core_pkg::op_kind_t   op
);

  rv_core_pkg::word_t    instr;
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  rv_core_pkg::reg_idx_t rd;
  rv_core_pkg::word_t    imm_i;
  rv_core_pkg::word_t    imm_s;
  rv_core_pkg::word_t    imm_b;
  rv_core_pkg::word_t    imm_u;
  rv_core_pkg::word_t    imm_j;
  rv_core_pkg::word_t    ld_addr;
  rv_core_pkg::word_t    st_addr;
  rv_core_pkg::word_t    link_pc;
  rv_core_pkg::word_t    result;
  rv_core_pkg::op_kind_t kind;
  logic                  wr_reg;
  logic                  take;

  assign instr  = pkt.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // immediates, all sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    kind = rv_core_pkg::op_nop; // unknown encodings fall through
    case (opcode)
      `OPC_OP: begin
        if (funct3 == `F3_ADD && funct7 == `F7_BASE) begin
          kind = rv_core_pkg::op_add;
        end else if (funct3 == `F3_ADD && funct7 == `F7_SUB) begin
          kind = rv_core_pkg::op_sub;
        end
      end
      `OPC_OPIMM: begin
        if (funct3 == `F3_ADDI) begin
          kind = rv_core_pkg::op_addi;
        end else if (funct3 == `F3_SLLI && funct7 == `F7_BASE) begin
          kind = rv_core_pkg::op_slli;
        end
      end
      `OPC_LOAD: begin
        if (funct3 == `F3_WORD) begin
          kind = rv_core_pkg::op_lw;
        end
      end
      `OPC_STORE: begin
        if (funct3 == `F3_WORD) begin
          kind = rv_core_pkg::op_sw;
        end
      end
      `OPC_AUIPC: kind = rv_core_pkg::op_auipc;
      `OPC_JAL:   kind = rv_core_pkg::op_jal;
      `OPC_BRANCH: begin
        if (funct3 == `F3_BEQ) begin
          kind = rv_core_pkg::op_beq;
        end else if (funct3 == `F3_BLTU) begin
          kind = rv_core_pkg::op_bltu;
        end
      end
      default: kind = rv_core_pkg::op_nop;
    endcase
  end

  assign ld_addr = rs1_data + imm_i;
  assign st_addr = rs1_data + imm_s;
  assign link_pc = pkt.pc + 32'd4;

  always_comb begin
    result = '0;
    wr_reg = 1'b1;
    case (kind)
      rv_core_pkg::op_add:   result = rs1_data + rs2_data;
      rv_core_pkg::op_sub:   result = rs1_data - rs2_data;
      rv_core_pkg::op_addi:  result = rs1_data + imm_i;
      rv_core_pkg::op_slli:  result = rs1_data << instr[24:20]; // shamt
      rv_core_pkg::op_lw:    result = dmem_data;
      rv_core_pkg::op_auipc: result = pkt.pc + imm_u;
      rv_core_pkg::op_jal:   result = link_pc;
      default:               wr_reg = 1'b0;
    endcase
  end

  always_comb begin
    case (kind)
      rv_core_pkg::op_jal:  take = 1'b1;
      rv_core_pkg::op_beq:  take = (rs1_data == rs2_data);
      rv_core_pkg::op_bltu: take = (rs1_data < rs2_data); // unsigned compare
      default:              take = 1'b0;
    endcase
  end

  assign dmem_idx = ld_addr[`MEM_IDX_W+1:2];

  assign rf_wr.en   = pkt.valid && wr_reg;
  assign rf_wr.idx  = rd;
  assign rf_wr.data = result;

  assign dm_wr.en   = pkt.valid && (kind == rv_core_pkg::op_sw);
  assign dm_wr.idx  = st_addr[`MEM_IDX_W+1:2];
  assign dm_wr.data = rs2_data;

  assign redirect.taken  = pkt.valid && take;
  assign redirect.target = pkt.pc + ((kind == rv_core_pkg::op_jal) ? imm_j : imm_b);

  assign op = pkt.valid ? kind : rv_core_pkg::op_nop;

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module fetch_unit (
  input  logic                    clk_cpu,
  input  logic                    rstn,
  input  logic                    debug,
  input  rv_core_pkg::word_t      imem_data,
  output rv_core_pkg::mem_idx_t   imem_idx,
  input  rv_core_pkg::redirect_t  redirect,
  output rv_core_pkg::fetch_pkt_t pkt,
  output rv_core_pkg::word_t      pc
);

  rv_core_pkg::fetch_state_t state_q;
  rv_core_pkg::word_t        pc_q;
  rv_core_pkg::word_t        next_pc;
  rv_core_pkg::word_t        pkt_pc_q;
  rv_core_pkg::word_t        pkt_instr_q;
  logic                      capture;

  // debug only holds the core between instructions
  assign capture = (state_q == rv_core_pkg::st_fetch) && !debug;
  assign next_pc = redirect.taken ? redirect.target : pc_q + 32'd4;

  always_ff @(posedge clk_cpu or negedge rstn) begin
    if (!rstn) begin
      state_q <= rv_core_pkg::st_fetch;
      pc_q    <= `RESET_PC;
    end else begin
      case (state_q)
        rv_core_pkg::st_fetch: begin
          if (capture) begin
            state_q <= rv_core_pkg::st_exec;
          end
        end
        rv_core_pkg::st_exec: begin
          pc_q    <= next_pc; // retire
          state_q <= rv_core_pkg::st_fetch;
        end
        default: state_q <= rv_core_pkg::st_fetch;
      endcase
    end
  end

  // fetched instruction record
  always_ff @(posedge clk_cpu) begin
    if (capture) begin
      pkt_pc_q    <= pc_q;
      pkt_instr_q <= imem_data;
    end
  end

  assign pkt.valid = (state_q == rv_core_pkg::st_exec);
  assign pkt.pc    = pkt_pc_q;
  assign pkt.instr = pkt_instr_q;

  assign imem_idx = pc_q[`MEM_IDX_W+1:2];
  assign pc       = pc_q;

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                  clk_cpu,
  input  logic                  rstn,
  input  rv_core_pkg::rf_wr_t   wr,
  input  rv_core_pkg::reg_idx_t rs1,
  input  rv_core_pkg::reg_idx_t rs2,
  output rv_core_pkg::word_t    rs1_data,
  output rv_core_pkg::word_t    rs2_data,
  input  rv_core_pkg::reg_idx_t dbg_idx,
  output rv_core_pkg::word_t    dbg_data
);

  rv_core_pkg::word_t regs [32];

  always_ff @(posedge clk_cpu or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.en && wr.idx != '0) begin // x0 stays zero
      regs[wr.idx] <= wr.data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];
  assign dbg_data = regs[dbg_idx];

endmodule

//--- design/rv_core_consts.svh
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

`define RESET_PC   32'h0000_3000
`define MEM_IDX_W  8
`define MEM_DEPTH  256

// major opcodes
`define OPC_OP     7'b0110011
`define OPC_OPIMM  7'b0010011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_BRANCH 7'b1100011

`define F3_ADD     3'b000
`define F3_WORD    3'b010 // lw and sw
`define F3_ADDI    3'b000
`define F3_SLLI    3'b001
`define F3_BEQ     3'b000
`define F3_BLTU    3'b110

`define F7_BASE    7'b0000000
`define F7_SUB     7'b0100000

`endif

//--- design/rv_core_pkg.sv
`include "rv_core_consts.svh"

package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [`MEM_IDX_W-1:0] mem_idx_t; // addr bits 9..2

  typedef enum logic [3:0] {
    op_nop,
    op_add,
    op_sub,
    op_addi,
    op_slli,
    op_lw,
    op_sw,
    op_auipc,
    op_jal,
    op_beq,
    op_bltu
  } op_kind_t;

  typedef enum logic {
    st_fetch,
    st_exec
  } fetch_state_t;

  typedef struct packed {
    logic  valid; // high in exec cycle only
    word_t pc;
    word_t instr;
  } fetch_pkt_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

  typedef struct packed {
    logic     en;
    reg_idx_t idx;
    word_t    data;
  } rf_wr_t;

  typedef struct packed {
    logic     en;
    mem_idx_t idx;
    word_t    data;
  } dm_wr_t;

endpackage

//--- design/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_core_top (
  input  logic                  clk_cpu,
  input  logic                  rstn,
  input  logic                  debug,
  input  rv_core_pkg::word_t    addr,
  input  rv_core_pkg::word_t    din,
  input  logic                  we_im,
  input  logic                  we_dm,
  output rv_core_pkg::word_t    dout_rf,
  output rv_core_pkg::word_t    dout_im,
  output rv_core_pkg::word_t    dout_dm,
  output rv_core_pkg::word_t    pc,
  output rv_core_pkg::word_t    instr,
  output rv_core_pkg::op_kind_t op
);

  rv_core_pkg::fetch_pkt_t pkt;
  rv_core_pkg::redirect_t  redirect;
  rv_core_pkg::rf_wr_t     rf_wr;
  rv_core_pkg::dm_wr_t     dm_wr;
  rv_core_pkg::dm_wr_t     dm_port;
  rv_core_pkg::mem_idx_t   imem_idx;
  rv_core_pkg::mem_idx_t   dmem_idx;
  rv_core_pkg::mem_idx_t   dbg_idx;
  rv_core_pkg::reg_idx_t   rs1;
  rv_core_pkg::reg_idx_t   rs2;
  rv_core_pkg::word_t      rs1_data;
  rv_core_pkg::word_t      rs2_data;
  rv_core_pkg::word_t      imem_data;
  rv_core_pkg::word_t      dmem_data;
  rv_core_pkg::word_t      rf_dbg;
  rv_core_pkg::word_t      im_dbg;
  rv_core_pkg::word_t      dm_dbg;

  assign dbg_idx = addr[`MEM_IDX_W+1:2];

  // dmem write port belongs to the debug side while halted
  assign dm_port = debug ? rv_core_pkg::dm_wr_t'{en: we_dm, idx: dbg_idx, data: din} : dm_wr;

  fetch_unit u_fetch (
    .clk_cpu  (clk_cpu),
    .rstn     (rstn),
    .debug    (debug),
    .imem_data(imem_data),
    .imem_idx (imem_idx),
    .redirect (redirect),
    .pkt      (pkt),
    .pc       (pc)
  );

  exec_unit u_exec (
    .pkt      (pkt),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dmem_idx (dmem_idx),
    .dmem_data(dmem_data),
    .rf_wr    (rf_wr),
    .dm_wr    (dm_wr),
    .redirect (redirect),
    .op       (op)
  );

  reg_file u_rf (
    .clk_cpu (clk_cpu),
    .rstn    (rstn),
    .wr      (rf_wr),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .dbg_idx (addr[4:0]),
    .dbg_data(rf_dbg)
  );

  word_ram u_imem (
    .clk_cpu  (clk_cpu),
    .we       (debug && we_im), // loaded only in debug
    .wr_idx   (dbg_idx),
    .wr_data  (din),
    .rd_idx_a (dbg_idx),
    .rd_data_a(im_dbg),
    .rd_idx_b (imem_idx),
    .rd_data_b(imem_data)
  );

  word_ram u_dmem (
    .clk_cpu  (clk_cpu),
    .we       (dm_port.en),
    .wr_idx   (dm_port.idx),
    .wr_data  (dm_port.data),
    .rd_idx_a (dbg_idx),
    .rd_data_a(dm_dbg),
    .rd_idx_b (dmem_idx),
    .rd_data_b(dmem_data)
  );

  assign dout_rf = debug ? rf_dbg : '0;
  assign dout_im = debug ? im_dbg : '0;
  assign dout_dm = debug ? dm_dbg : '0;
  assign instr   = pkt.instr;

endmodule

//--- design/word_ram.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module word_ram (
  input  logic                  clk_cpu,
  input  logic                  we,
  input  rv_core_pkg::mem_idx_t wr_idx,
  input  rv_core_pkg::word_t    wr_data,
  input  rv_core_pkg::mem_idx_t rd_idx_a,
  output rv_core_pkg::word_t    rd_data_a,
  input  rv_core_pkg::mem_idx_t rd_idx_b,
  output rv_core_pkg::word_t    rd_data_b
);

  rv_core_pkg::word_t mem [`MEM_DEPTH];

  always_ff @(posedge clk_cpu) begin
    if (we) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // both read ports are asynchronous
  assign rd_data_a = mem[rd_idx_a];
  assign rd_data_b = mem[rd_idx_b];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -f rv_core_top.f --top-module rv_core_tb -o rv_core_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/rv_core_sim > sim.log 2>&1
cat sim.log

grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

//--- rv_core_top.f
+incdir+design
design/rv_core_pkg.sv
design/word_ram.sv
design/reg_file.sv
design/fetch_unit.sv
design/exec_unit.sv
design/rv_core_top.sv
verif/tb_clock.sv
verif/rv_core_tb.sv

//--- verif/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_core_tb;

  localparam int N_INSTR_MAX = 130; // all programs together
  localparam int N_CTRL = 40;
  // runs, program loads, memory preload, register and memory dumps, reset
  localparam int WATCH_CYCLES = 2 * (2 * N_INSTR_MAX + 2 * N_INSTR_MAX + 3 * `MEM_DEPTH
                                     + 5 * (32 + `MEM_DEPTH) + 16);

  logic                  clk_cpu;
  logic                  rstn;
  logic                  debug;
  rv_core_pkg::word_t    addr;
  rv_core_pkg::word_t    din;
  logic                  we_im;
  logic                  we_dm;
  rv_core_pkg::word_t    dout_rf;
  rv_core_pkg::word_t    dout_im;
  rv_core_pkg::word_t    dout_dm;
  rv_core_pkg::word_t    pc;
  rv_core_pkg::word_t    instr;
  rv_core_pkg::op_kind_t op;

  // model state
  rv_core_pkg::word_t m_rf [32];
  rv_core_pkg::word_t m_dm [`MEM_DEPTH];
  rv_core_pkg::word_t m_im [`MEM_DEPTH];
  rv_core_pkg::word_t m_pc;
  rv_core_pkg::word_t prog [$];

  tb_clock #(.PERIOD_NS(8.0)) u_clk (.clk_cpu(clk_cpu));

  rv_core_top u_dut (
    .clk_cpu(clk_cpu),
    .rstn   (rstn),
    .debug  (debug),
    .addr   (addr),
    .din    (din),
    .we_im  (we_im),
    .we_dm  (we_dm),
    .dout_rf(dout_rf),
    .dout_im(dout_im),
    .dout_dm(dout_dm),
    .pc     (pc),
    .instr  (instr),
    .op     (op)
  );

  function automatic rv_core_pkg::word_t r_type(int f7, int rs2, int rs1, int f3, int rd,
                                                logic [6:0] opc);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic rv_core_pkg::word_t i_type(int imm, int rs1, int f3, int rd,
                                                logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic rv_core_pkg::word_t s_type(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], `OPC_STORE};
  endfunction

  function automatic rv_core_pkg::word_t b_type(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], `OPC_BRANCH};
  endfunction

  function automatic rv_core_pkg::word_t u_type(int imm, int rd, logic [6:0] opc);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic rv_core_pkg::word_t j_type(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OPC_JAL};
  endfunction

  function automatic rv_core_pkg::word_t fill_pattern(logic [7:0] i);
    return {i, ~i, i ^ 8'ha5, i + 8'h3c};
  endfunction

  // one instruction of the ISA model, returns the expected op kind
  function automatic rv_core_pkg::op_kind_t ref_step();
    rv_core_pkg::word_t    ins;
    rv_core_pkg::word_t    a;
    rv_core_pkg::word_t    b;
    rv_core_pkg::word_t    res;
    rv_core_pkg::word_t    nxt;
    rv_core_pkg::word_t    ea;
    rv_core_pkg::word_t    imm_i;
    rv_core_pkg::word_t    imm_s;
    rv_core_pkg::word_t    imm_b;
    rv_core_pkg::word_t    imm_j;
    logic [6:0]            opc;
    logic [2:0]            f3;
    logic [6:0]            f7;
    logic [4:0]            rd;
    logic                  wen;
    rv_core_pkg::op_kind_t k;
    ins   = m_im[m_pc[9:2]];
    opc   = ins[6:0];
    f3    = ins[14:12];
    f7    = ins[31:25];
    rd    = ins[11:7];
    a     = m_rf[ins[19:15]];
    b     = m_rf[ins[24:20]];
    imm_i = 32'($signed(ins[31:20]));
    imm_s = 32'($signed({ins[31:25], ins[11:7]}));
    imm_b = 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
    imm_j = 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
    k     = rv_core_pkg::op_nop;
    wen   = 1'b0;
    res   = '0;
    nxt   = m_pc + 32'd4;
    case (opc)
      `OPC_OP: begin
        if (f3 == 3'b000 && f7 == 7'h00) begin
          k   = rv_core_pkg::op_add;
          res = a + b;
          wen = 1'b1;
        end else if (f3 == 3'b000 && f7 == 7'h20) begin
          k   = rv_core_pkg::op_sub;
          res = a - b;
          wen = 1'b1;
        end
      end
      `OPC_OPIMM: begin
        if (f3 == `F3_ADDI) begin
          k   = rv_core_pkg::op_addi;
          res = a + imm_i;
          wen = 1'b1;
        end else if (f3 == `F3_SLLI && f7 == 7'h00) begin
          k   = rv_core_pkg::op_slli;
          res = a << ins[24:20];
          wen = 1'b1;
        end
      end
      `OPC_LOAD: begin
        if (f3 == 3'b010) begin
          k   = rv_core_pkg::op_lw;
          ea  = a + imm_i;
          res = m_dm[ea[9:2]];
          wen = 1'b1;
        end
      end
      `OPC_STORE: begin
        if (f3 == 3'b010) begin
          k = rv_core_pkg::op_sw;
          ea = a + imm_s;
          m_dm[ea[9:2]] = b;
        end
      end
      `OPC_AUIPC: begin
        k   = rv_core_pkg::op_auipc;
        res = m_pc + {ins[31:12], 12'h000};
        wen = 1'b1;
      end
      `OPC_JAL: begin
        k   = rv_core_pkg::op_jal;
        res = m_pc + 32'd4;
        wen = 1'b1;
        nxt = m_pc + imm_j;
      end
      `OPC_BRANCH: begin
        if (f3 == `F3_BEQ) begin
          k = rv_core_pkg::op_beq;
          if (a == b) nxt = m_pc + imm_b;
        end else if (f3 == `F3_BLTU) begin
          k = rv_core_pkg::op_bltu;
          if (a < b) nxt = m_pc + imm_b;
        end
      end
      default: k = rv_core_pkg::op_nop;
    endcase
    if (wen && rd != 5'd0) m_rf[rd] = res; // x0 stays zero
    m_pc = nxt;
    return k;
  endfunction

  task automatic check_word(input string name, input rv_core_pkg::word_t got,
                            input rv_core_pkg::word_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h exp %h", name, got, exp);
      $display("Verification failed");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_op(input rv_core_pkg::op_kind_t got, input rv_core_pkg::op_kind_t exp);
    if (got !== exp) begin
      $display("FAIL op got %h exp %h", got, exp);
      $display("Verification failed");
      $fatal(1, "op mismatch");
    end
  endtask

  task automatic debug_write(input logic to_im, input logic [7:0] idx,
                             input rv_core_pkg::word_t data);
    addr  = {22'd0, idx, 2'b00};
    din   = data;
    we_im = to_im;
    we_dm = !to_im;
    @(posedge clk_cpu);
    @(negedge clk_cpu);
    we_im = 1'b0;
    we_dm = 1'b0;
  endtask

  // registers and whole data memory against the model
  task automatic compare_state();
    for (int i = 0; i < 32; i++) begin
      addr = 32'(i);
      @(negedge clk_cpu);
      check_word($sformatf("dout_rf[%0d]", i), dout_rf, m_rf[i]);
    end
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      addr = 32'(i) << 2;
      @(negedge clk_cpu);
      check_word($sformatf("dout_dm[%0d]", i), dout_dm, m_dm[i]);
    end
  endtask

  // program goes at the current pc, the core stays halted
  task automatic load_program();
    rv_core_pkg::word_t pc_before;
    logic [7:0]         idx;
    pc_before = pc;
    for (int i = 0; i < prog.size(); i++) begin
      idx = m_pc[9:2] + 8'(i);
      debug_write(1'b1, idx, prog[i]);
      m_im[idx] = prog[i];
    end
    for (int i = 0; i < prog.size(); i++) begin
      idx  = m_pc[9:2] + 8'(i);
      addr = {22'd0, idx, 2'b00};
      @(negedge clk_cpu);
      check_word("dout_im", dout_im, prog[i]);
    end
    check_word("pc", pc, pc_before);
  endtask

  task automatic run_program(input int n);
    rv_core_pkg::op_kind_t exp_op;
    rv_core_pkg::word_t    exp_instr;
    debug = 1'b0;
    for (int i = 0; i < n; i++) begin
      exp_instr = m_im[m_pc[9:2]];
      exp_op    = ref_step();
      @(posedge clk_cpu);
      @(negedge clk_cpu);
      check_op(op, exp_op); // exec cycle
      check_word("instr", instr, exp_instr);
      @(posedge clk_cpu);
      @(negedge clk_cpu);
      check_word("pc", pc, m_pc);
    end
    debug = 1'b1;
  endtask

  task automatic build_arith();
    rv_core_pkg::word_t rnd;
    prog.delete();
    for (int r = 1; r <= 8; r++) begin
      rnd = $urandom;
      prog.push_back(i_type(int'(rnd[11:0]), 0, `F3_ADDI, r, `OPC_OPIMM));
    end
    for (int k = 0; k < 32; k++) begin
      rnd = $urandom;
      case (rnd[1:0])
        2'd0: prog.push_back(r_type(0, int'(rnd[13:10]), int'(rnd[9:6]), `F3_ADD,
                                    int'(rnd[5:2]), `OPC_OP));
        2'd1: prog.push_back(r_type(32, int'(rnd[13:10]), int'(rnd[9:6]), `F3_ADD,
                                    int'(rnd[5:2]), `OPC_OP));
        2'd2: prog.push_back(i_type(int'(rnd[25:14]), int'(rnd[9:6]), `F3_ADDI,
                                    int'(rnd[5:2]), `OPC_OPIMM));
        default: prog.push_back(i_type(int'(rnd[30:26]), int'(rnd[9:6]), `F3_SLLI,
                                       int'(rnd[5:2]), `OPC_OPIMM));
      endcase
    end
  endtask

  task automatic build_mem();
    rv_core_pkg::word_t rnd;
    prog.delete();
    prog.push_back(i_type(400, 0, `F3_ADDI, 11, `OPC_OPIMM));
    for (int k = 0; k < 12; k++) begin
      rnd = $urandom;
      prog.push_back(s_type(int'(rnd[7:0]) * 4, int'(rnd[11:8]), 0, `F3_WORD));
      prog.push_back(i_type((k % 2 == 0) ? int'(rnd[7:0]) * 4 : int'(rnd[21:14]) * 4, 0,
                            `F3_WORD, 16 + int'(rnd[13:12]), `OPC_LOAD));
    end
    prog.push_back(s_type(-16, 3, 11, `F3_WORD)); // negative store offset
    prog.push_back(i_type(-16, 11, `F3_WORD, 21, `OPC_LOAD));
    rnd = $urandom;
    prog.push_back(u_type(int'(rnd[19:0]), 12, `OPC_AUIPC));
    prog.push_back(u_type(32'hfffff, 13, `OPC_AUIPC));
  endtask

  task automatic build_ctrl();
    prog.delete();
    prog.push_back(i_type(0, 0, `F3_ADDI, 1, `OPC_OPIMM));
    prog.push_back(i_type(5, 0, `F3_ADDI, 2, `OPC_OPIMM));
    prog.push_back(i_type(1, 1, `F3_ADDI, 1, `OPC_OPIMM)); // loop body
    prog.push_back(b_type(-4, 2, 1, `F3_BLTU));
    prog.push_back(b_type(8, 2, 1, `F3_BEQ));             // taken
    prog.push_back(i_type(99, 0, `F3_ADDI, 3, `OPC_OPIMM));
    prog.push_back(j_type(8, 4));
    prog.push_back(i_type(7, 0, `F3_ADDI, 5, `OPC_OPIMM));
    prog.push_back(i_type(-1, 0, `F3_ADDI, 6, `OPC_OPIMM));
    prog.push_back(b_type(8, 1, 6, `F3_BLTU));            // signed less, unsigned not
    prog.push_back(i_type(3, 0, `F3_ADDI, 7, `OPC_OPIMM));
    prog.push_back(b_type(8, 6, 1, `F3_BLTU));            // taken
    prog.push_back(i_type(1, 0, `F3_ADDI, 8, `OPC_OPIMM));
    prog.push_back(b_type(8, 0, 1, `F3_BEQ));             // not taken
    prog.push_back(j_type(0, 9));                         // spins here
  endtask

  task automatic build_unknown();
    prog.delete();
    prog.push_back(u_type(32'h12345, 1, 7'b0110111));
    prog.push_back(b_type(8, 2, 1, 1));
    prog.push_back(r_type(1, 2, 1, 0, 3, `OPC_OP));
    prog.push_back(i_type(0, 0, 0, 4, `OPC_LOAD));
    prog.push_back(s_type(0, 1, 0, 0));
    prog.push_back(i_type(5, 1, 2, 5, `OPC_OPIMM));
    prog.push_back(i_type(1024, 1, `F3_SLLI, 6, `OPC_OPIMM));
    prog.push_back(32'h0000_0000);
    prog.push_back(32'hffff_ffff);
    prog.push_back(32'h0000_0073);
  endtask

  initial begin
    repeat (WATCH_CYCLES) @(posedge clk_cpu);
    $display("timeout: run did not finish within %0d cycles", WATCH_CYCLES);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rv_core_pkg::word_t nop;
    void'($urandom(32'h9418_8ec0));
    rstn  = 1'b0;
    debug = 1'b1;
    addr  = '0;
    din   = '0;
    we_im = 1'b0;
    we_dm = 1'b0;
    for (int i = 0; i < 32; i++) m_rf[i] = '0;
    m_pc = `RESET_PC;
    repeat (2) @(posedge clk_cpu);
    @(negedge clk_cpu);
    rstn = 1'b1;

    check_word("pc", pc, `RESET_PC);
    for (int i = 0; i < 32; i++) begin
      addr = 32'(i);
      @(negedge clk_cpu);
      check_word($sformatf("dout_rf[%0d]", i), dout_rf, 32'h0);
    end

    // preload both memories through the debug port
    nop = i_type(0, 0, `F3_ADDI, 0, `OPC_OPIMM);
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      debug_write(1'b1, 8'(i), nop);
      m_im[i] = nop;
      debug_write(1'b0, 8'(i), fill_pattern(8'(i)));
      m_dm[i] = fill_pattern(8'(i));
    end
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      addr = 32'(i) << 2;
      @(negedge clk_cpu);
      check_word("dout_im", dout_im, m_im[i]);
      check_word("dout_dm", dout_dm, m_dm[i]);
    end
    check_word("pc", pc, `RESET_PC);

    build_arith();
    load_program();
    run_program(prog.size());
    compare_state();

    build_mem();
    load_program();
    run_program(prog.size());
    compare_state();

    build_ctrl();
    load_program();
    run_program(N_CTRL);
    compare_state();

    build_unknown();
    load_program();
    run_program(prog.size());
    compare_state();

    $display("Verification passed");
    $finish;
  end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk_cpu
);

  initial begin
    clk_cpu = 1'b0;
  end

  always #(PERIOD_NS / 2.0) clk_cpu = ~clk_cpu;

endmodule
